// ==== sources.f ====
verilog/xy_pkg.sv
verilog/wrap_counter.sv
verilog/xy_ram.sv
verilog/xy_buffer.sv
verilog/vector_accumulator.sv
verilog/lstm_stage3.sv
tests/tb_lstm_stage3.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the stage 3 testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module tb_lstm_stage3 \
	-o sim_lstm_stage3
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_lstm_stage3)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Finished with no errors"; then
	exit 0
fi
echo "simulation reported a failure"
exit 1

// ==== tests/stage3_vectors.txt ====
# cmd lane0 lane1 lane2 lane3 in hex. X and Y are one entry, S is one expected pass sum
# F n starts a feed and sends n more feed pulses while the replay runs
# timestep 1
X 00001 3FFFF 00100 1FFFF
X 00002 3FFFE 3FF00 1FFFF
X 00003 3FFFD 00010 1FFFF
X 00004 3FFFC 3FFF0 1FFFF
Y 00010 20000 00ABC 10000
Y 00020 20000 3F544 10000
Y 00030 3FFF0 01234 10000
Y 00040 3FFF0 00000 10000
Y 00050 00005 12345 00001
Y 00060 00005 2DCBB 00001
Y 00070 00007 0A0A0 00002
Y 00080 00008 00001 00003
S 000024A 3FBFFEF 000B2D5 00C0003
S 000024A 3FBFFEF 000B2D5 00C0003
S 000024A 3FBFFEF 000B2D5 00C0003
F 0
# timestep 2
X 3FFFF 00100 00007 20000
X 3FFFE 00200 00007 20000
X 3FFFD 00300 00007 00000
X 3FFFC 00400 00007 00000
Y 00000 00010 11111 00001
Y 00000 00020 22222 00001
Y 00000 00030 33333 00001
Y 00000 00040 04444 00001
Y 00001 00050 05555 00001
Y 00001 00060 06666 00001
Y 00001 00070 07777 00001
Y 00001 00080 08888 00001
S 3FFFFFA 0000C40 0006680 3FC0008
S 3FFFFFA 0000C40 0006680 3FC0008
S 3FFFFFA 0000C40 0006680 3FC0008
F 2

// ==== tests/tb_lstm_stage3.sv ====
`timescale 1ns/100ps

module tb_lstm_stage3;

	localparam int X_LEN = 4;
	localparam int Y_LEN = 8;
	localparam int PASSES = 3;
	localparam int DEPTH = X_LEN + Y_LEN;
	localparam int WAIT_LIMIT = PASSES * DEPTH + 40;

	logic clk;
	logic reset;
	xy_pkg::beat_t i_x;
	xy_pkg::beat_t i_y;
	logic i_feed_start;
	logic o_ready;
	xy_pkg::beat_t o_stream;
	logic o_sum_valid;
	xy_pkg::sum_vec_t o_sum;

	logic [31:0] lfsr;
	logic timed_out;
	int checks;
	int value_errors;
	int other_errors;
	int x_writes;
	int y_writes;
	int feed_beats;
	int feed_sums;
	xy_pkg::lane_vec_t x_entries[$];
	xy_pkg::lane_vec_t y_entries[$];
	xy_pkg::lane_vec_t exp_beats[$];
	xy_pkg::sum_vec_t exp_sums[$];
	xy_pkg::sum_vec_t file_sums[$];

	lstm_stage3 #(
		.X_LEN(X_LEN),
		.Y_LEN(Y_LEN),
		.PASSES(PASSES)
	) u_lstm_stage3 (
		.clk(clk),
		.reset(reset),
		.i_x(i_x),
		.i_y(i_y),
		.i_feed_start(i_feed_start),
		.o_ready(o_ready),
		.o_stream(o_stream),
		.o_sum_valid(o_sum_valid),
		.o_sum(o_sum)
	);

	always #50 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic check_equal(input string name, input logic [127:0] want,
			input logic [127:0] got);
		checks++;
		assert (got === want) else begin
			$display("[ERROR] %s: expected %0h, got %0h", name, want, got);
			value_errors++;
		end
	endtask

	task automatic check_condition(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s", what);
			other_errors++;
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	task automatic sample_outputs();
		xy_pkg::lane_vec_t want;
		int beats_before;
		beats_before = feed_beats;
		if (o_stream.valid) begin
			check_condition(exp_beats.size() > 0, "stream beat arrived when none was expected");
			if (exp_beats.size() > 0) begin
				want = exp_beats.pop_front();
				check_equal($sformatf("o_stream.data beat %0d", feed_beats), want, o_stream.data);
			end
			feed_beats++;
		end else if (feed_beats > 0) begin
			check_condition(exp_beats.size() == 0,
				$sformatf("gap in the replay stream after beat %0d", feed_beats));
		end
		if (o_sum_valid) begin
			check_condition(exp_sums.size() > 0, "sum arrived when none was expected");
			// a sum comes one cycle after the last beat of its pass
			check_equal("beats before o_sum_valid", (feed_sums + 1) * DEPTH, beats_before);
			if (exp_sums.size() > 0) begin
				check_equal($sformatf("o_sum pass %0d", feed_sums), exp_sums.pop_front(), o_sum);
			end
			feed_sums++;
		end
	endtask

	task automatic next_cycle();
		@(negedge clk);
		if (!reset) begin
			sample_outputs();
		end
	endtask

	// 0 to 3 idle cycles from two lfsr bits
	task automatic idle_gap();
		int gap;
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			lfsr = lfsr_next(lfsr);
			gap = (gap << 1) | int'(lfsr[0]);
		end
		repeat (gap) next_cycle();
	endtask

	task automatic write_entry(input logic is_x, input xy_pkg::lane_vec_t data);
		logic want_ready;
		check_condition(o_ready == is_x, is_x ? "X write attempted while o_ready is low" :
			"Y write attempted while o_ready is high");
		if (o_ready == is_x) begin
			if (is_x) begin
				i_x = '{valid: 1'b1, data: data};
				x_entries.push_back(data);
				x_writes++;
			end else begin
				i_y = '{valid: 1'b1, data: data};
				y_entries.push_back(data);
				y_writes++;
			end
			next_cycle();
			i_x.valid = 1'b0;
			i_y.valid = 1'b0;
			// ready drops with the last X write and comes back with the last Y write
			want_ready = is_x ? (x_writes < X_LEN) : (y_writes == Y_LEN);
			check_equal("o_ready", want_ready, o_ready);
		end
	endtask

	task automatic run_feed(input int extra_feeds);
		xy_pkg::lane_vec_t pass_order[$];
		xy_pkg::sum_vec_t model;
		xy_pkg::sum_vec_t listed;
		int cycles;
		int sent;
		model = '0;
		foreach (y_entries[i]) begin
			pass_order.push_back(y_entries[i]);
		end
		foreach (x_entries[i]) begin
			pass_order.push_back(x_entries[i]);
		end
		// each lane sign-extended and summed over the whole buffer with wrap at SUM_W
		foreach (pass_order[i]) begin
			for (int l = 0; l < xy_pkg::LANES; l++) begin
				model[l] = model[l] + xy_pkg::sum_t'(pass_order[i][l]);
			end
		end
		check_equal("listed sums per feed", PASSES, file_sums.size());
		while (file_sums.size() > 0) begin
			listed = file_sums.pop_front();
			check_equal("listed sum vs written data", model, listed);
			exp_sums.push_back(listed);
		end
		for (int p = 0; p < PASSES; p++) begin
			foreach (pass_order[i]) begin
				exp_beats.push_back(pass_order[i]);
			end
		end
		feed_beats = 0;
		feed_sums = 0;
		i_feed_start = 1'b1;
		next_cycle();
		i_feed_start = 1'b0;
		sent = 0;
		cycles = 0;
		while ((feed_beats < PASSES * DEPTH || feed_sums < PASSES) && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
			if (i_feed_start) begin
				i_feed_start = 1'b0;
			end else if (sent < extra_feeds && feed_beats >= 5 + 4 * sent) begin
				// lands mid replay and must not start another one
				i_feed_start = 1'b1;
				sent++;
			end
		end
		i_feed_start = 1'b0;
		if (feed_beats < PASSES * DEPTH || feed_sums < PASSES) begin
			check_condition(1'b0,
				$sformatf("timeout waiting for the replay, %0d beats and %0d sums seen",
				feed_beats, feed_sums));
			timed_out = 1'b1;
			return;
		end
		// any late beat or sum in this quiet window shows up as unexpected
		cycles = 0;
		while (cycles < 2 * DEPTH) begin
			next_cycle();
			cycles++;
		end
		check_equal("replay beat count", PASSES * DEPTH, feed_beats);
		check_equal("sum count", PASSES, feed_sums);
		x_entries.delete();
		y_entries.delete();
		x_writes = 0;
		y_writes = 0;
	endtask

	task automatic end_run();
		$display("checks %0d, value errors %0d, other errors %0d", checks, value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	initial begin
		int fd;
		int n;
		string line;
		logic [7:0] cmd;
		logic [31:0] v0;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] v3;
		clk = 1'b0;
		reset = 1'b1;
		i_x = '0;
		i_y = '0;
		i_feed_start = 1'b0;
		lfsr = 32'h4422_6c97;
		timed_out = 1'b0;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		x_writes = 0;
		y_writes = 0;
		feed_beats = 0;
		feed_sums = 0;
		repeat (4) next_cycle();
		reset = 1'b0;
		check_equal("o_ready", 1'b1, o_ready);
		check_equal("o_stream.valid", 1'b0, o_stream.valid);
		check_equal("o_sum_valid", 1'b0, o_sum_valid);

		fd = $fopen("tests/stage3_vectors.txt", "r");
		check_condition(fd != 0, "could not open tests/stage3_vectors.txt");
		while (fd != 0 && !$feof(fd) && !timed_out) begin
			n = $fgets(line, fd);
			if (n > 0) begin
				v0 = '0;
				n = $sscanf(line, "%c %h %h %h %h", cmd, v0, v1, v2, v3);
				case (cmd)
					"X", "Y": begin
						idle_gap();
						write_entry(cmd == "X", {v3[17:0], v2[17:0], v1[17:0], v0[17:0]});
					end
					"S": begin
						file_sums.push_back({v3[25:0], v2[25:0], v1[25:0], v0[25:0]});
					end
					"F": begin
						run_feed(int'(v0));
					end
					"#", " ", "\n", "\r": begin
					end
					default: begin
						check_condition(1'b0, $sformatf("unknown command in vector file: %s", line));
					end
				endcase
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		end_run();
	end

endmodule

// ==== verilog/lstm_stage3.sv ====
`timescale 1ns/100ps

module lstm_stage3 #(
	parameter int X_LEN = 4,
	parameter int Y_LEN = 8,
	parameter int PASSES = 3
) (
	input logic clk,
	input logic reset,
	input xy_pkg::beat_t i_x,
	input xy_pkg::beat_t i_y,
	input logic i_feed_start,
	output logic o_ready,
	output xy_pkg::beat_t o_stream,
	output logic o_sum_valid,
	output xy_pkg::sum_vec_t o_sum
);

	xy_pkg::beat_t stream;
	logic pass_end;

	xy_buffer #(
		.X_LEN(X_LEN),
		.Y_LEN(Y_LEN),
		.PASSES(PASSES)
	) u_xy_buffer (
		.clk(clk),
		.reset(reset),
		.i_x(i_x),
		.i_y(i_y),
		.i_feed_start(i_feed_start),
		.o_ready(o_ready),
		.o_stream(stream),
		.o_pass_end(pass_end)
	);

	// stands in for the matrix-vector unit downstream
	vector_accumulator u_vector_accumulator (
		.clk(clk),
		.reset(reset),
		.i_stream(stream),
		.i_pass_end(pass_end),
		.o_sum_valid(o_sum_valid),
		.o_sum(o_sum)
	);

	assign o_stream = stream;

endmodule

// ==== verilog/vector_accumulator.sv ====
`timescale 1ns/100ps

module vector_accumulator (
	input logic clk,
	input logic reset,
	input xy_pkg::beat_t i_stream,
	input logic i_pass_end,
	output logic o_sum_valid,
	output xy_pkg::sum_vec_t o_sum
);

	xy_pkg::sum_vec_t acc;
	xy_pkg::sum_vec_t acc_next;

	// sign-extend each lane and add, wraps at SUM_W
	always_comb begin
		for (int l = 0; l < xy_pkg::LANES; l++) begin
			acc_next[l] = acc[l] + xy_pkg::sum_t'(i_stream.data[l]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
			o_sum_valid <= 1'b0;
		end else begin
			o_sum_valid <= i_stream.valid && i_pass_end;
			if (i_stream.valid) begin
				// restart from zero so the next pass can follow directly
				if (i_pass_end) begin
					acc <= '0;
				end else begin
					acc <= acc_next;
				end
			end
		end
	end

	// result register holds the last completed pass
	always_ff @(posedge clk) begin
		if (i_stream.valid && i_pass_end) begin
			o_sum <= acc_next;
		end
	end

	// pass end comes from the buffer and must sit on a real beat
	pass_end_on_beat: assert property (
		@(posedge clk) disable iff (reset)
		i_pass_end |-> i_stream.valid
	) else $error("vector_accumulator: pass end flagged without a valid beat");

	// the sum pulse is always a single cycle wide
	sum_pulse_single: assert property (
		@(posedge clk) disable iff (reset)
		o_sum_valid |=> !o_sum_valid
	) else $error("vector_accumulator: o_sum_valid held for more than one cycle");

endmodule

// ==== verilog/xy_buffer.sv ====
`timescale 1ns/100ps

module xy_buffer #(
	parameter int X_LEN = 4,
	parameter int Y_LEN = 8,
	parameter int PASSES = 3
) (
	input logic clk,
	input logic reset,
	input xy_pkg::beat_t i_x,
	input xy_pkg::beat_t i_y,
	input logic i_feed_start,
	output logic o_ready,
	output xy_pkg::beat_t o_stream,
	output logic o_pass_end
);

	localparam int DEPTH = Y_LEN + X_LEN;
	localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int PASS_W = (PASSES > 1) ? $clog2(PASSES) : 1;

	logic wen;
	xy_pkg::lane_vec_t wdata;
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_addr;
	logic [PASS_W-1:0] pass_cnt;
	logic feed_pending;
	logic rd_en;
	logic rd_valid;
	logic pass_end;
	logic last_entry;
	logic last_read;
	logic replay_start;
	xy_pkg::lane_vec_t rd_data;

	// ready high means the X region is open, otherwise Y is written
	always_comb begin
		if (o_ready) begin
			wen = i_x.valid;
			wdata = i_x.data;
		end else begin
			wen = i_y.valid;
			wdata = i_y.data;
		end
	end

	// X lives at Y_LEN and up, Y at 0 to Y_LEN-1
	wrap_counter #(
		.WIDTH(ADDR_W),
		.WRAP_AT(DEPTH - 1),
		.RESET_VAL(Y_LEN)
	) u_wr_ptr (
		.clk(clk),
		.reset(reset),
		.i_enable(wen),
		.o_count(wr_ptr)
	);

	// tracks the pointer after this edge
	always_ff @(posedge clk) begin
		if (reset) begin
			o_ready <= 1'b1;
		end else if (wen) begin
			o_ready <= (wr_ptr >= ADDR_W'(Y_LEN - 1)) && (wr_ptr != ADDR_W'(DEPTH - 1));
		end
	end

	assign last_entry = (rd_addr == ADDR_W'(DEPTH - 1));
	assign last_read = rd_en && last_entry && (pass_cnt == PASS_W'(PASSES - 1));
	assign replay_start = feed_pending && !rd_en && (wr_ptr == ADDR_W'(Y_LEN));

	wrap_counter #(
		.WIDTH(ADDR_W),
		.WRAP_AT(DEPTH - 1),
		.RESET_VAL(0)
	) u_rd_addr (
		.clk(clk),
		.reset(reset),
		.i_enable(rd_en),
		.o_count(rd_addr)
	);

	wrap_counter #(
		.WIDTH(PASS_W),
		.WRAP_AT(PASSES - 1),
		.RESET_VAL(0)
	) u_pass_cnt (
		.clk(clk),
		.reset(reset),
		.i_enable(rd_en && last_entry),
		.o_count(pass_cnt)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			feed_pending <= 1'b0;
			rd_en <= 1'b0;
		end else begin
			if (last_read) begin
				feed_pending <= 1'b0;
			end else if (i_feed_start && !rd_en) begin
				feed_pending <= 1'b1;
			end
			if (replay_start) begin
				rd_en <= 1'b1;
			end else if (last_read) begin
				rd_en <= 1'b0;
			end
		end
	end

	// one cycle behind the read to line up with the ram output
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid <= 1'b0;
			pass_end <= 1'b0;
		end else begin
			rd_valid <= rd_en;
			pass_end <= rd_en && last_entry;
		end
	end

	xy_ram #(
		.DEPTH(DEPTH),
		.ADDR_W(ADDR_W)
	) u_xy_ram (
		.clk(clk),
		.i_wen(wen),
		.i_waddr(wr_ptr),
		.i_wdata(wdata),
		.i_raddr(rd_addr),
		.o_rdata(rd_data)
	);

	assign o_stream = '{valid: rd_valid, data: rd_data};
	assign o_pass_end = pass_end;

	no_write_in_replay: assert property (
		@(posedge clk) disable iff (reset)
		rd_en |-> !wen
	) else $error("xy_buffer: write at address %0d during replay", wr_ptr);

	x_only_when_ready: assert property (
		@(posedge clk) disable iff (reset)
		!o_ready |-> !i_x.valid
	) else $error("xy_buffer: i_x valid while o_ready low");

	y_only_when_not_ready: assert property (
		@(posedge clk) disable iff (reset)
		o_ready |-> !i_y.valid
	) else $error("xy_buffer: i_y valid while o_ready high");

endmodule

// ==== verilog/xy_ram.sv ====
`timescale 1ns/100ps

module xy_ram #(
	parameter int DEPTH = 12,
	parameter int ADDR_W = 4
) (
	input logic clk,
	input logic i_wen,
	input logic [ADDR_W-1:0] i_waddr,
	input xy_pkg::lane_vec_t i_wdata,
	input logic [ADDR_W-1:0] i_raddr,
	output xy_pkg::lane_vec_t o_rdata
);

	xy_pkg::lane_vec_t mem [DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// read port, registered, one cycle of latency
	always_ff @(posedge clk) begin
		o_rdata <= mem[i_raddr];
	end

	write_in_range: assert property (
		@(posedge clk)
		i_wen |-> (i_waddr < ADDR_W'(DEPTH))
	) else $error("xy_ram: write address %0d beyond depth %0d", i_waddr, DEPTH);

endmodule

// ==== verilog/wrap_counter.sv ====
`timescale 1ns/100ps

module wrap_counter #(
	parameter int WIDTH = 4,
	parameter int WRAP_AT = 15,
	parameter int RESET_VAL = 0
) (
	input logic clk,
	input logic reset,
	input logic i_enable,
	output logic [WIDTH-1:0] o_count
);

	always_ff @(posedge clk) begin
		if (reset) begin
			o_count <= WIDTH'(RESET_VAL);
		end else if (i_enable) begin
			// back to zero after the last value
			if (o_count == WIDTH'(WRAP_AT)) begin
				o_count <= '0;
			end else begin
				o_count <= o_count + 1'b1;
			end
		end
	end

	// also catches a reset value set beyond the wrap point
	count_in_range: assert property (
		@(posedge clk) disable iff (reset)
		o_count <= WIDTH'(WRAP_AT)
	) else $error("wrap_counter: count %0d above wrap point %0d", o_count, WRAP_AT);

endmodule

// ==== verilog/xy_pkg.sv ====
package xy_pkg;

	// lanes per buffer entry, the types below are sized from it
	localparam int LANES = 4;
	localparam int DATA_W = 18;
	// accumulator lane width, sums wrap here
	localparam int SUM_W = 26;

	typedef logic signed [DATA_W-1:0] sample_t;

	// one buffer entry, lane 0 in the low bits
	typedef sample_t [LANES-1:0] lane_vec_t;

	// shared by the X input, the Y input and the replay stream
	typedef struct packed {
		logic valid;
		lane_vec_t data;
	} beat_t;

	typedef logic signed [SUM_W-1:0] sum_t;

	typedef sum_t [LANES-1:0] sum_vec_t;

endpackage
